// File: verif/simd_alu_golden.txt
# op vew vxrm operand_a operand_b expected_result expected_vxsat
# all hex, op numbered from VAND = 00 to VMSLTU = 16
03 0 0 0102030405060708 FF7F80017F0010F0 00818305840617F8 00
03 1 0 0001FFFF80001234 FFFF0001800000FF 0000000000001333 00
04 2 0 0000000100000005 0000000000000010 FFFFFFFF0000000B 00
05 1 0 0010000000050100 00010001000500FF 000FFFFF00000001 00
0C 0 0 0001020307080F09 8181818181818181 8102040880818002 00
0D 1 0 0000000400080010 8000F0F0ABCD1234 80000F0F00AB1234 00
0E 2 0 000000040000001F 800000007FFFFFFF F800000000000000 00
0E 0 0 0703010007030100 808080807F7F7F7F FFF0C080000F3F7F 00
0C 3 0 0000000000000044 F00000000000000F 00000000000000F0 00
06 0 0 FF01800010FF7F01 01FE7F00F0FF8000 FFFFFF00FFFFFF01 8C
07 1 0 7FFF80000001FFFF 0001FFFF00028000 7FFF800000038000 F3
08 2 0 0000001000000001 0000000F00000003 0000000000000002 F0
09 0 0 01FF807F10000180 807F00802000007F 807F7F801000FF7F F1
09 3 0 0000000000000001 8000000000000000 8000000000000000 FF
0A 0 0 01010203FFFF0080 00020102FF010081 01020203FF800081 00
0A 0 1 01010203FFFF0080 00020102FF010081 00020202FF800080 00
0A 0 2 01010203FFFF0080 00020102FF010081 00010102FF800080 00
0A 0 3 01010203FFFF0080 00020102FF010081 01010103FF800081 00
0B 1 0 7FFF8000FFFF0003 7FFF8001FFFE0000 7FFF8001FFFF0002 00
0B 1 1 7FFF8000FFFF0003 7FFF8001FFFE0000 7FFF8000FFFE0002 00
0B 1 2 7FFF8000FFFF0003 7FFF8001FFFE0000 7FFF8000FFFE0001 00
0B 1 3 7FFF8000FFFF0003 7FFF8001FFFE0000 7FFF8001FFFF0001 00
0F 0 0 01FF807F00102030 02017F8000201030 01017F7F00101030 00
10 0 0 01FF807F00102030 02017F8000201030 01FF808000101030 00
11 0 0 01FF807F00102030 02017F8000201030 02FF808000202030 00
12 0 0 01FF807F00102030 02017F8000201030 02017F7F00202030 00
13 1 0 12340000FFFF8000 12340001FFFF0000 0001000000010000 00
14 1 0 12340000FFFF8000 12340001FFFF0000 0000000100000001 00
15 0 0 0180007FFF050500 007FFF80FE050601 0100010101000000 00
16 0 0 0180007FFF050500 007FFF80FE050601 0101000001000000 00
16 3 0 8000000000000000 7FFFFFFFFFFFFFFF 0000000000000001 00

// File: sim.f
+incdir+rtl
rtl/simd_alu_pkg.sv
rtl/simd_elem_cmp.sv
rtl/simd_elem_alu.sv
rtl/simd_alu.sv
verif/simd_alu_assertions.sv
verif/simd_alu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module simd_alu_tb -f sim.f -Mdir obj_dir
	@out="$$(./obj_dir/Vsimd_alu_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: verif/simd_alu_tb.sv
////////////////////////////////////////////////////////////
// SIMD vector ALU testbench
// Golden vector replay and random logical operation checks
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "simd_alu_defs.svh"

module simd_alu_tb;

  localparam int TIMEOUT_CYC = 8;
  localparam int NUM_RAND    = 12;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    valid_i;
  simd_alu_pkg::alu_op_e   op_i;
  simd_alu_pkg::vew_e      vew_i;
  simd_alu_pkg::vxrm_e     vxrm_i;
  logic [`SIMD_DATA_W-1:0] operand_a_i;
  logic [`SIMD_DATA_W-1:0] operand_b_i;
  logic                    valid_o;
  logic [`SIMD_DATA_W-1:0] result_o;
  logic [`SIMD_STRB_W-1:0] vxsat_o;

  int     value_errs;
  int     other_errs;
  int     vec_count;
  integer seed;

  // Expected outputs of the most recent vector
  logic [`SIMD_DATA_W-1:0] last_res;
  logic [`SIMD_STRB_W-1:0] last_sat;

  simd_alu simd_alu_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .vxrm_i      (vxrm_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_field(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // Applies one word and checks it one cycle later
  task automatic run_vector(input logic [4:0] op, input logic [1:0] vew,
                            input logic [1:0] rm, input logic [63:0] a,
                            input logic [63:0] b, input logic [63:0] exp_res,
                            input logic [7:0] exp_sat);
    int cycles;
    op_i        = simd_alu_pkg::alu_op_e'(op);
    vew_i       = simd_alu_pkg::vew_e'(vew);
    vxrm_i      = simd_alu_pkg::vxrm_e'(rm);
    operand_a_i = a;
    operand_b_i = b;
    valid_i     = 1'b1;
    last_res    = exp_res;
    last_sat    = exp_sat;
    @(posedge clk_i);
    #2;
    valid_i = 1'b0;
    vec_count++;
    cycles = 0;
    while (!valid_o && cycles < TIMEOUT_CYC) begin
      @(posedge clk_i);
      #2;
      cycles++;
    end
    if (!valid_o) begin
      other_errs++;
      $display("Timed out waiting for valid_o on vector %0d", vec_count);
    end else if (cycles != 0) begin
      other_errs++;
      $display("valid_o came %0d cycles late on vector %0d", cycles, vec_count);
    end else begin
      check_field("result_o", exp_res, result_o);
      check_field("vxsat_o", {56'd0, exp_sat}, {56'd0, vxsat_o});
    end
  endtask

  // Idle cycle with saturating inputs must leave the last result in place
  task automatic hold_while_idle();
    valid_i     = 1'b0;
    op_i        = simd_alu_pkg::VSADDU;
    vew_i       = simd_alu_pkg::EW8;
    operand_a_i = '1;
    operand_b_i = '1;
    @(posedge clk_i);
    #2;
    check_field("valid_o", 64'd0, {63'd0, valid_o});
    check_field("result_o", last_res, result_o);
    check_field("vxsat_o", {56'd0, last_sat}, {56'd0, vxsat_o});
  endtask

  task automatic replay_golden();
    int          fd;
    int          rc;
    int          line_no;
    string       line;
    logic [4:0]  op;
    logic [1:0]  vew;
    logic [1:0]  rm;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp_res;
    logic [7:0]  exp_sat;
    fd = $fopen("verif/simd_alu_golden.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("The golden vector file could not be opened");
    end else begin
      line_no = 0;
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        line_no++;
        if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%h %h %h %h %h %h %h", op, vew, rm, a, b, exp_res, exp_sat);
          if (rc != 7) begin
            other_errs++;
            $display("Golden file line %0d could not be read", line_no);
          end else begin
            run_vector(op, vew, rm, a, b, exp_res, exp_sat);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // AND, OR and XOR on random words
  task automatic random_logical();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp_res;
    logic [4:0]  op;
    for (int i = 0; i < NUM_RAND; i++) begin
      a  = {$random(seed), $random(seed)};
      b  = {$random(seed), $random(seed)};
      op = 5'(i % 3);
      if (op == 5'd0)
        exp_res = a & b;
      else if (op == 5'd1)
        exp_res = a | b;
      else
        exp_res = a ^ b;
      run_vector(op, 2'(i % 4), 2'(i / 4), a, b, exp_res, 8'd0);
    end
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = simd_alu_pkg::VAND;
    vew_i       = simd_alu_pkg::EW8;
    vxrm_i      = simd_alu_pkg::RNU;
    operand_a_i = '0;
    operand_b_i = '0;
    value_errs  = 0;
    other_errs  = 0;
    vec_count   = 0;
    last_res    = '0;
    last_sat    = '0;
    seed        = 32'hccd1cf89;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #2;
    check_field("valid_o", 64'd0, {63'd0, valid_o});
    check_field("result_o", 64'd0, result_o);
    check_field("vxsat_o", 64'd0, {56'd0, vxsat_o});
    replay_golden();
    if (vec_count == 0) begin
      other_errs++;
      $display("No golden vectors were applied");
    end
    hold_while_idle();
    random_logical();
    $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verif/simd_alu_assertions.sv
////////////////////////////////////////////////////////////
// SIMD vector ALU assertions
// Valid timing, reset and saturation flag properties
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "simd_alu_defs.svh"

module simd_alu_assertions (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    valid_i,
  input simd_alu_pkg::alu_op_e   op_i,
  input logic                    valid_o,
  input logic [`SIMD_STRB_W-1:0] vxsat_o
);

  logic sat_op;

  assign sat_op = op_i inside {simd_alu_pkg::VSADDU, simd_alu_pkg::VSADD,
                               simd_alu_pkg::VSSUBU, simd_alu_pkg::VSSUB};

  a_valid_reset: assert property (@(posedge clk_i) !rst_n_i |=> !valid_o)
    else $error("valid_o high in the cycle after reset");

  // One cycle latency, no stall
  a_valid_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  $past(rst_n_i) |-> valid_o == $past(valid_i))
    else $error("valid_o does not follow valid_i by one cycle");

  a_sat_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                valid_i && !sat_op |=> vxsat_o == '0)
    else $error("vxsat_o set after a non-saturating operation");

endmodule

bind simd_alu simd_alu_assertions i_simd_alu_assertions (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (valid_i),
  .op_i    (op_i),
  .valid_o (valid_o),
  .vxsat_o (vxsat_o)
);

// File: rtl/simd_alu.sv
////////////////////////////////////////////////////////////
// SIMD vector ALU
// One 64-bit word per cycle split into 8, 16, 32 or 64-bit
// elements, with the result and saturation flags registered
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "simd_alu_defs.svh"

module simd_alu (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  simd_alu_pkg::alu_op_e   op_i,
  input  simd_alu_pkg::vew_e      vew_i,
  input  simd_alu_pkg::vxrm_e     vxrm_i,
  input  logic [`SIMD_DATA_W-1:0] operand_a_i,
  input  logic [`SIMD_DATA_W-1:0] operand_b_i,
  output logic                    valid_o,
  output logic [`SIMD_DATA_W-1:0] result_o,
  output logic [`SIMD_STRB_W-1:0] vxsat_o
);

  localparam int unsigned NUM_EW = 4;
  localparam int unsigned BYTE_W = `SIMD_DATA_W / `SIMD_STRB_W;

  logic [NUM_EW-1:0][`SIMD_DATA_W-1:0] res_ew;
  logic [NUM_EW-1:0][`SIMD_STRB_W-1:0] sat_ew;
  logic [`SIMD_DATA_W-1:0]             res_sel;
  logic [`SIMD_STRB_W-1:0]             sat_sel;

  ////////////////////////////////////////////////////////////
  // Element arrays, one per element width
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_EW; w++) begin : gen_ew
    localparam int unsigned EW = BYTE_W << w;
    localparam int unsigned NE = `SIMD_DATA_W / EW;
    localparam int unsigned NB = EW / BYTE_W;

    for (genvar e = 0; e < NE; e++) begin : gen_elem
      logic sat;

      simd_elem_alu #(
        .elem_t (logic [EW-1:0])
      ) i_elem_alu (
        .a_i      (operand_a_i[e*EW +: EW]),
        .b_i      (operand_b_i[e*EW +: EW]),
        .op_i     (op_i),
        .vxrm_i   (vxrm_i),
        .result_o (res_ew[w][e*EW +: EW]),
        .sat_o    (sat)
      );

      // Flag covers every byte of the element
      assign sat_ew[w][e*NB +: NB] = {NB{sat}};
    end
  end

  // EW8 to EW64 map onto array index 0 to 3
  assign res_sel = res_ew[vew_i];
  assign sat_sel = sat_ew[vew_i];

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      valid_o <= valid_i;
      // Hold the last result while idle
      if (valid_i) begin
        result_o <= res_sel;
        vxsat_o  <= sat_sel;
      end
    end
  end

endmodule

// File: rtl/simd_elem_alu.sv
////////////////////////////////////////////////////////////
// SIMD element ALU
// All vector ALU operations on one element of any width,
// with fixed-point rounding and saturation detection
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "simd_alu_defs.svh"

module simd_elem_alu #(
  parameter type elem_t = logic [7:0]
) (
  input  elem_t                 a_i,
  input  elem_t                 b_i,
  input  simd_alu_pkg::alu_op_e op_i,
  input  simd_alu_pkg::vxrm_e   vxrm_i,
  output elem_t                 result_o,
  output logic                  sat_o
);

  localparam int unsigned W    = $bits(elem_t);
  localparam int unsigned SH_W = $clog2(W);

  logic            op_legal;
  logic            arith_signed;
  logic            cmp_signed;
  logic [W:0]      a_ext;
  logic [W:0]      b_ext;
  logic [W:0]      sum;
  logic [W:0]      diff;
  logic            sum_ovf;
  logic            diff_ovf;
  logic            rnd;
  elem_t           avg;
  elem_t           max_pos;
  elem_t           min_neg;
  logic [SH_W-1:0] shamt;
  logic            less;
  logic            equal;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign op_legal     = (op_i < `SIMD_OP_NUM);
  assign arith_signed = op_i inside {simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB,
                                     simd_alu_pkg::VAADD};
  assign cmp_signed   = op_i inside {simd_alu_pkg::VMIN, simd_alu_pkg::VMAX,
                                     simd_alu_pkg::VMSLT};

  ////////////////////////////////////////////////////////////
  // Widened sum and difference
  ////////////////////////////////////////////////////////////

  assign a_ext = {arith_signed & a_i[W-1], a_i};
  assign b_ext = {arith_signed & b_i[W-1], b_i};
  assign sum   = a_ext + b_ext;
  assign diff  = b_ext - a_ext;

  // Carry or borrow when unsigned, top two bits disagree when signed
  assign sum_ovf  = arith_signed ? (sum[W] ^ sum[W-1]) : sum[W];
  assign diff_ovf = arith_signed ? (diff[W] ^ diff[W-1]) : diff[W];

  assign max_pos = {1'b0, {(W-1){1'b1}}};
  assign min_neg = {1'b1, {(W-1){1'b0}}};

  // Rounding increment from the bit shifted out and the new LSB
  always_comb begin
    unique case (vxrm_i)
      simd_alu_pkg::RNU: rnd = sum[0];
      simd_alu_pkg::RNE: rnd = sum[1] & sum[0];
      simd_alu_pkg::RDN: rnd = 1'b0;
      simd_alu_pkg::ROD: rnd = ~sum[1] & sum[0];
      default:           rnd = 1'b0;
    endcase
  end

  assign avg   = sum[W:1] + {{(W-1){1'b0}}, rnd};
  assign shamt = a_i[SH_W-1:0];

  simd_elem_cmp #(
    .elem_t (elem_t)
  ) i_elem_cmp (
    .a_i         (a_i),
    .b_i         (b_i),
    .is_signed_i (cmp_signed),
    .less_o      (less),
    .equal_o     (equal)
  );

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    sat_o    = 1'b0;

    if (op_legal) begin
      unique case (op_i)
        simd_alu_pkg::VAND:  result_o = a_i & b_i;
        simd_alu_pkg::VOR:   result_o = a_i | b_i;
        simd_alu_pkg::VXOR:  result_o = a_i ^ b_i;

        simd_alu_pkg::VADD:  result_o = sum[W-1:0];
        simd_alu_pkg::VSUB:  result_o = diff[W-1:0];
        simd_alu_pkg::VRSUB: result_o = a_i - b_i;

        simd_alu_pkg::VSADDU: begin
          sat_o    = sum_ovf;
          result_o = sum_ovf ? '1 : sum[W-1:0];
        end
        simd_alu_pkg::VSADD: begin
          sat_o    = sum_ovf;
          result_o = sum_ovf ? (sum[W] ? min_neg : max_pos) : sum[W-1:0];
        end
        simd_alu_pkg::VSSUBU: begin
          sat_o    = diff_ovf;
          result_o = diff_ovf ? '0 : diff[W-1:0];
        end
        simd_alu_pkg::VSSUB: begin
          sat_o    = diff_ovf;
          result_o = diff_ovf ? (diff[W] ? min_neg : max_pos) : diff[W-1:0];
        end

        simd_alu_pkg::VAADDU, simd_alu_pkg::VAADD: result_o = avg;

        simd_alu_pkg::VSLL: result_o = b_i << shamt;
        simd_alu_pkg::VSRL: result_o = b_i >> shamt;
        simd_alu_pkg::VSRA: result_o = $signed(b_i) >>> shamt;

        simd_alu_pkg::VMINU, simd_alu_pkg::VMIN: result_o = less ? b_i : a_i;
        simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX: result_o = less ? a_i : b_i;

        // Compare result in bit 0 only
        simd_alu_pkg::VMSEQ:  result_o[0] = equal;
        simd_alu_pkg::VMSNE:  result_o[0] = ~equal;
        simd_alu_pkg::VMSLT,
        simd_alu_pkg::VMSLTU: result_o[0] = less;

        default: ;
      endcase
    end
  end

endmodule

// File: rtl/simd_elem_cmp.sv
////////////////////////////////////////////////////////////
// SIMD element compare
// Signed or unsigned less-than of b against a, and equality
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module simd_elem_cmp #(
  parameter type elem_t = logic [7:0]
) (
  input  elem_t a_i,
  input  elem_t b_i,
  input  logic  is_signed_i,
  output logic  less_o,
  output logic  equal_o
);

  localparam int unsigned W = $bits(elem_t);

  logic [W:0] a_ext;
  logic [W:0] b_ext;

  // One extra bit makes a single signed compare serve both cases
  assign a_ext = {is_signed_i & a_i[W-1], a_i};
  assign b_ext = {is_signed_i & b_i[W-1], b_i};

  assign less_o  = $signed(b_ext) < $signed(a_ext);
  assign equal_o = (a_i == b_i);

endmodule

// File: rtl/simd_alu_pkg.sv
////////////////////////////////////////////////////////////
// SIMD vector ALU package
// Operation, element width and rounding mode types
////////////////////////////////////////////////////////////

`include "simd_alu_defs.svh"

package simd_alu_pkg;

  // Codes are numbered in this order starting at zero
  typedef enum logic [`SIMD_OP_W-1:0] {
    // Logical
    VAND, VOR, VXOR,
    // Wrapping arithmetic
    VADD, VSUB, VRSUB,
    // Saturating arithmetic
    VSADDU, VSADD, VSSUBU, VSSUB,
    // Averaging add
    VAADDU, VAADD,
    // Shifts
    VSLL, VSRL, VSRA,
    // Min and max
    VMINU, VMIN, VMAXU, VMAX,
    // Mask compares
    VMSEQ, VMSNE, VMSLT, VMSLTU
  } alu_op_e;

  typedef enum logic [`SIMD_EW_W-1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Fixed-point rounding modes
  typedef enum logic [`SIMD_RM_W-1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } vxrm_e;

endpackage

// File: rtl/simd_alu_defs.svh
////////////////////////////////////////////////////////////
// SIMD vector ALU global definitions
// Datapath, byte lane and operation code widths
////////////////////////////////////////////////////////////

`ifndef SIMD_ALU_DEFS_SVH
`define SIMD_ALU_DEFS_SVH

// One 64-bit word per cycle
`define SIMD_DATA_W 64

// Byte lanes, also one saturation flag each
`define SIMD_STRB_W 8

// Operation code
`define SIMD_OP_W   5
`define SIMD_OP_NUM 23

// Element width and rounding mode selectors
`define SIMD_EW_W   2
`define SIMD_RM_W   2

`endif
